//--- Bender.yml
package:
  name: fcu_issue

sources:
  # Packages first, then the interface and the modules bottom up
  - design/thor_queue_pkg.sv
  - design/thor_fcu_pkg.sv
  - design/iq_state_if.sv
  - design/fcu_issue_select.sv
  - design/issue_queue.sv
  - design/flow_control_unit.sv
  - design/fcu_issue_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - testbench/fcu_issue_properties.sv
      - testbench/fcu_issue_tb.sv

//--- design/fcu_issue_select.sv
/*
 * FCU issue selector
 * Finds the oldest issuable flow control entry that passes the sync rule
 */

`timescale 1ns/100ps
`default_nettype none

module fcu_issue_select
    import thor_queue_pkg::*;
(
    input  logic       clk,
    iq_state_if.select sel,
    input  logic       fcu_idle
);

    // Slot number of each program order position, position 0 is the head
    que_ndx_t pos [QENTRIES];

    // Bit k is set when position k passes the sync rule
    logic [QENTRIES-1:0] sync_ok;

    que_bitmask_t issue_mask;

    always_comb begin
        for (int k = 0; k < QENTRIES; k++) begin
            pos[k] = sel.head + que_ndx_t'(k);
        end
    end

    // =====================================================================
    // Sync rule
    // =====================================================================

    // A valid sync entry at position j blocks every younger position
    // as long as anything older than it is still valid
    // The scan starts at position 1 on purpose. A sync entry at the head
    // has nothing older to wait for, so it never blocks anyone
    // Positions 0 and 1 therefore always pass
    always_comb begin : sync_scan
        logic any_older;
        logic blocked;
        any_older = sel.v[pos[0]];
        blocked = 1'b0;
        sync_ok[0] = 1'b1;
        sync_ok[1] = 1'b1;
        for (int k = 1; k < QENTRIES - 1; k++) begin
            if (sel.v[pos[k]] && sel.sync[pos[k]] && any_older) begin
                blocked = 1'b1;
            end
            any_older = any_older | sel.v[pos[k]];
            sync_ok[k+1] = !blocked;
        end
    end

    // =====================================================================
    // Oldest first pick
    // =====================================================================

    // Nothing is picked while the FCU is busy with a branch
    always_comb begin : pick
        logic found;
        found = 1'b0;
        issue_mask = '0;
        if (fcu_idle) begin
            for (int k = 0; k < QENTRIES; k++) begin
                if (!found && sel.could_issue[pos[k]] && sel.fc[pos[k]] && sync_ok[k]) begin
                    issue_mask[pos[k]] = 1'b1;
                    found = 1'b1;
                end
            end
        end
    end

    assign sel.fcu_issue = issue_mask;

endmodule : fcu_issue_select

`default_nettype wire

//--- design/fcu_issue_top.sv
/*
 * Flow control issue stage top level
 * Queue, FCU selector and flow control unit behind plain ports
 */

`timescale 1ns/100ps
`default_nettype none

module fcu_issue_top
    import thor_queue_pkg::*;
    import thor_fcu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     enq_valid,
    input  logic     enq_fc,
    input  logic     enq_sync,
    input  fcu_op_t  enq_op,
    input  opnd_t    enq_a,
    input  opnd_t    enq_b,
    input  logic     alu_done,
    input  que_ndx_t alu_done_tag,
    output que_ndx_t enq_tag,
    output logic     queue_full,
    output logic     issue_valid,
    output que_ndx_t issue_tag,
    output logic     br_valid,
    output que_ndx_t br_tag,
    output logic     br_taken,
    output logic     retire_valid,
    output que_ndx_t retire_tag
);

    // Hand-off from the queue to the FCU
    fcu_op_t issue_op;
    opnd_t   issue_a;
    opnd_t   issue_b;
    logic    fcu_idle;

    iq_state_if iq_state_if_inst ();

    issue_queue issue_queue_inst (
        .clk          (clk),
        .rst          (rst),
        .enq_valid    (enq_valid),
        .enq_fc       (enq_fc),
        .enq_sync     (enq_sync),
        .enq_op       (enq_op),
        .enq_a        (enq_a),
        .enq_b        (enq_b),
        .alu_done     (alu_done),
        .alu_done_tag (alu_done_tag),
        .br_valid     (br_valid),
        .br_tag       (br_tag),
        .fcu_idle     (fcu_idle),
        .enq_tag      (enq_tag),
        .queue_full   (queue_full),
        .issue_go     (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_tag    (issue_tag),
        .retire_valid (retire_valid),
        .retire_tag   (retire_tag),
        .q            (iq_state_if_inst.queue)
    );

    fcu_issue_select fcu_issue_select_inst (
        .clk      (clk),
        .sel      (iq_state_if_inst.select),
        .fcu_idle (fcu_idle)
    );

    flow_control_unit flow_control_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .issue_go  (issue_valid),
        .issue_op  (issue_op),
        .issue_a   (issue_a),
        .issue_b   (issue_b),
        .issue_tag (issue_tag),
        .fcu_idle  (fcu_idle),
        .br_valid  (br_valid),
        .br_tag    (br_tag),
        .br_taken  (br_taken)
    );

endmodule : fcu_issue_top

`default_nettype wire

//--- design/flow_control_unit.sv
/*
 * Flow control unit
 * Resolves one branch at a time over FCU_LATENCY cycles
 */

`timescale 1ns/100ps
`default_nettype none

module flow_control_unit
    import thor_queue_pkg::*;
    import thor_fcu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     issue_go,
    input  fcu_op_t  issue_op,
    input  opnd_t    issue_a,
    input  opnd_t    issue_b,
    input  que_ndx_t issue_tag,
    output logic     fcu_idle,
    output logic     br_valid,
    output que_ndx_t br_tag,
    output logic     br_taken
);

    fcu_state_t state;

    // Branch held for the duration of the evaluation
    fcu_op_t  op_q;
    opnd_t    a_q;
    opnd_t    b_q;
    que_ndx_t tag_q;
    logic     taken_q;

    logic taken;

    // Branch condition from the latched operands
    always_comb begin
        case (op_q)
            BEQ:     taken = (a_q == b_q);
            BNE:     taken = (a_q != b_q);
            BLT:     taken = ($signed(a_q) < $signed(b_q));
            default: taken = 1'b1;
        endcase
    end

    // IDLE accepts a branch, EVAL resolves it and DONE reports it
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FCU_IDLE;
        end else begin
            case (state)
                FCU_IDLE: if (issue_go) state <= FCU_EVAL;
                FCU_EVAL: state <= FCU_DONE;
                default:  state <= FCU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FCU_IDLE && issue_go) begin
            op_q  <= issue_op;
            a_q   <= issue_a;
            b_q   <= issue_b;
            tag_q <= issue_tag;
        end
        if (state == FCU_EVAL) begin
            taken_q <= taken;
        end
    end

    assign fcu_idle = (state == FCU_IDLE);
    assign br_valid = (state == FCU_DONE);
    assign br_tag   = tag_q;
    assign br_taken = taken_q;

endmodule : flow_control_unit

`default_nettype wire

//--- design/iq_state_if.sv
/*
 * Queue state bundle between the instruction queue and the FCU selector
 * Carries per-slot flags and the head pointer out and the selection back
 */

`timescale 1ns/100ps
`default_nettype none

interface iq_state_if
    import thor_queue_pkg::*;
();

    // Per-slot flags published by the queue
    que_bitmask_t v;
    que_bitmask_t fc;
    que_bitmask_t sync;
    que_bitmask_t could_issue;

    // Slot holding the oldest entry
    que_ndx_t head;

    // One-hot selection of the slot to send to the FCU, or zero
    que_bitmask_t fcu_issue;

    modport queue (
        output v, fc, sync, could_issue, head,
        input  fcu_issue
    );

    modport select (
        input  v, fc, sync, could_issue, head,
        output fcu_issue
    );

endinterface : iq_state_if

`default_nettype wire

//--- design/issue_queue.sv
/*
 * Circular instruction queue with eight slots
 * Enqueue at the tail, FCU issue hand-off, completion marking
 * and in-order retire from the head
 */

`timescale 1ns/100ps
`default_nettype none

module issue_queue
    import thor_queue_pkg::*;
    import thor_fcu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       enq_valid,
    input  logic       enq_fc,
    input  logic       enq_sync,
    input  fcu_op_t    enq_op,
    input  opnd_t      enq_a,
    input  opnd_t      enq_b,
    input  logic       alu_done,
    input  que_ndx_t   alu_done_tag,
    input  logic       br_valid,
    input  que_ndx_t   br_tag,
    input  logic       fcu_idle,
    output que_ndx_t   enq_tag,
    output logic       queue_full,
    output logic       issue_go,
    output fcu_op_t    issue_op,
    output opnd_t      issue_a,
    output opnd_t      issue_b,
    output que_ndx_t   issue_tag,
    output logic       retire_valid,
    output que_ndx_t   retire_tag,
    iq_state_if.queue  q
);

    // Per-slot control flags
    que_bitmask_t v;
    que_bitmask_t fc;
    que_bitmask_t sync;
    que_bitmask_t issued;
    que_bitmask_t done;

    // Per-slot payload
    fcu_op_t op_q [QENTRIES];
    opnd_t   a_q  [QENTRIES];
    opnd_t   b_q  [QENTRIES];

    que_ndx_t head;
    que_ndx_t tail;
    logic [$clog2(QENTRIES+1)-1:0] count;

    logic enq_fire;

    // =====================================================================
    // Enqueue and retire status
    // =====================================================================

    assign queue_full = (count == QENTRIES);
    assign enq_tag    = tail;
    assign enq_fire   = enq_valid && !queue_full;

    // The head retires once it has completed
    assign retire_valid = v[head] && done[head];
    assign retire_tag   = head;

    // =====================================================================
    // Queue view for the selector
    // =====================================================================

    assign q.v    = v;
    assign q.fc   = fc;
    assign q.sync = sync;
    assign q.head = head;

    // Only flow control entries that still wait for the FCU are candidates
    assign q.could_issue = v & ~issued & fc;

    // Encode the one-hot selection into a slot tag
    always_comb begin
        issue_tag = '0;
        for (int i = 0; i < QENTRIES; i++) begin
            if (q.fcu_issue[i]) begin
                issue_tag = que_ndx_t'(i);
            end
        end
    end

    // The selector already holds off while the FCU is busy
    // Gating again keeps a stray pick from reaching a busy FCU
    assign issue_go = (|q.fcu_issue) && fcu_idle;
    assign issue_op = op_q[issue_tag];
    assign issue_a  = a_q[issue_tag];
    assign issue_b  = b_q[issue_tag];

    // =====================================================================
    // Control state
    // =====================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            v      <= '0;
            fc     <= '0;
            sync   <= '0;
            issued <= '0;
            done   <= '0;
            head   <= '0;
            tail   <= '0;
            count  <= '0;
        end else begin
            if (issue_go) begin
                issued[issue_tag] <= 1'b1;
            end
            // Branch results complete the slot the FCU was working on
            if (br_valid && v[br_tag]) begin
                done[br_tag] <= 1'b1;
            end
            // Strobes for empty or flow control slots are dropped
            if (alu_done && v[alu_done_tag] && !fc[alu_done_tag]) begin
                done[alu_done_tag] <= 1'b1;
            end
            if (retire_valid) begin
                v[head] <= 1'b0;
                head    <= head + 1'b1;
            end
            // The tail slot is free here, so no other update above touches it
            if (enq_fire) begin
                v[tail]      <= 1'b1;
                fc[tail]     <= enq_fc;
                sync[tail]   <= enq_sync;
                issued[tail] <= 1'b0;
                done[tail]   <= 1'b0;
                tail         <= tail + 1'b1;
            end
            case ({enq_fire, retire_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Operands and opcode are written with the entry
    always_ff @(posedge clk) begin
        if (enq_fire) begin
            op_q[tail] <= enq_op;
            a_q[tail]  <= enq_a;
            b_q[tail]  <= enq_b;
        end
    end

endmodule : issue_queue

`default_nettype wire

//--- design/thor_fcu_pkg.sv
/*
 * Flow control unit definitions
 * Operand width and type, branch opcodes, latency and FSM states
 */

`default_nettype none

package thor_fcu_pkg;

    // Width of a branch operand
    localparam int OPND_W = 32;

    // Cycles from the edge that accepts an issue to the result pulse
    localparam int FCU_LATENCY = 2;

    // =====================================================================
    // FCU types
    // =====================================================================

    typedef logic [OPND_W-1:0] opnd_t;

    // Flow control opcodes handled by the FCU
    typedef enum logic [1:0] {BEQ, BNE, BLT, JMP} fcu_op_t;

    // Resolver states
    // EVAL and DONE together take FCU_LATENCY cycles
    typedef enum logic [1:0] {FCU_IDLE, FCU_EVAL, FCU_DONE} fcu_state_t;

endpackage : thor_fcu_pkg

`default_nettype wire

//--- design/thor_queue_pkg.sv
/*
 * Instruction queue geometry
 * Slot index and per-slot bit mask types
 */

`default_nettype none

package thor_queue_pkg;

    // Number of entries in the circular instruction queue
    localparam int QENTRIES = 8;

    // =====================================================================
    // Queue types
    // =====================================================================

    // Slot index into the queue
    // Arithmetic on it wraps modulo QENTRIES because the width is exact
    typedef logic [$clog2(QENTRIES)-1:0] que_ndx_t;

    // One bit per queue slot, indexed by slot number and not by age
    typedef logic [QENTRIES-1:0] que_bitmask_t;

endpackage : thor_queue_pkg

`default_nettype wire

//--- fcu_issue_top.f
design/thor_queue_pkg.sv
design/thor_fcu_pkg.sv
design/iq_state_if.sv
design/fcu_issue_select.sv
design/issue_queue.sv
design/flow_control_unit.sv
design/fcu_issue_top.sv
testbench/fcu_issue_properties.sv
testbench/fcu_issue_tb.sv

//--- testbench/fcu_issue_properties.sv
/*
 * Concurrent assertions for the FCU selector and the flow control unit
 * One checker module, bound into both modules with the signals each one owns
 */

`timescale 1ns/100ps
`default_nettype none

module fcu_issue_properties
    import thor_queue_pkg::*;
    import thor_fcu_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input que_bitmask_t fcu_issue,
    input logic         fcu_idle,
    input logic         issue_go,
    input logic         br_valid
);

    // At most one slot is sent to the FCU in a cycle
    one_hot_pick: assert property (@(posedge clk) disable iff (rst) $onehot0(fcu_issue))
        else $error("FCU selection has more than one bit set");

    // A busy FCU must not be offered a new branch
    idle_pick: assert property (@(posedge clk) disable iff (rst) (|fcu_issue) |-> fcu_idle)
        else $error("FCU selection made while the FCU is busy");

    // The result pulse comes exactly FCU_LATENCY edges after the accepting edge
    result_after_issue: assert property (@(posedge clk) disable iff (rst)
        issue_go |-> ##FCU_LATENCY br_valid)
        else $error("Branch result missing FCU_LATENCY cycles after issue");

    no_stray_result: assert property (@(posedge clk) disable iff (rst)
        br_valid |-> $past(issue_go, FCU_LATENCY))
        else $error("Branch result without a matching issue");

endmodule : fcu_issue_properties

// The selector has no reset and no branch signals, so those inputs are tied low
bind fcu_issue_select fcu_issue_properties select_props (
    .clk       (clk),
    .rst       (1'b0),
    .fcu_issue (issue_mask),
    .fcu_idle  (fcu_idle),
    .issue_go  (1'b0),
    .br_valid  (1'b0)
);

bind flow_control_unit fcu_issue_properties fcu_props (
    .clk       (clk),
    .rst       (rst),
    .fcu_issue ('0),
    .fcu_idle  (fcu_idle),
    .issue_go  (issue_go),
    .br_valid  (br_valid)
);

`default_nettype wire

//--- testbench/fcu_issue_tb.sv
/*
 * Testbench for the flow control issue stage
 * Clock and reset, directed and random stimulus, a model of the queue,
 * the reference selector and a compare process that runs every cycle
 */

`timescale 1ns/100ps
`default_nettype none

module fcu_issue_tb
    import thor_queue_pkg::*;
    import thor_fcu_pkg::*;
();

    logic     clk;
    logic     rst;
    logic     enq_valid;
    logic     enq_fc;
    logic     enq_sync;
    fcu_op_t  enq_op;
    opnd_t    enq_a;
    opnd_t    enq_b;
    logic     alu_done;
    que_ndx_t alu_done_tag;
    que_ndx_t enq_tag;
    logic     queue_full;
    logic     issue_valid;
    que_ndx_t issue_tag;
    logic     br_valid;
    que_ndx_t br_tag;
    logic     br_taken;
    logic     retire_valid;
    que_ndx_t retire_tag;

    // Queue model, always in step with the DUT state after the last edge
    que_bitmask_t m_v;
    que_bitmask_t m_fc;
    que_bitmask_t m_sync;
    que_bitmask_t m_issued;
    que_bitmask_t m_done;
    fcu_op_t      m_op [QENTRIES];
    opnd_t        m_a  [QENTRIES];
    opnd_t        m_b  [QENTRIES];
    que_ndx_t     m_head;
    que_ndx_t     m_tail;
    int           m_count;

    // FCU model, busy counts down the edges until the FCU is idle again
    int       busy;
    que_ndx_t pend_tag;

    int errors;
    int tests_run;
    int tests_failed;
    int issues_seen;
    int branches_seen;
    int retires_seen;

    fcu_issue_top fcu_issue_top_inst (
        .clk          (clk),
        .rst          (rst),
        .enq_valid    (enq_valid),
        .enq_fc       (enq_fc),
        .enq_sync     (enq_sync),
        .enq_op       (enq_op),
        .enq_a        (enq_a),
        .enq_b        (enq_b),
        .alu_done     (alu_done),
        .alu_done_tag (alu_done_tag),
        .enq_tag      (enq_tag),
        .queue_full   (queue_full),
        .issue_valid  (issue_valid),
        .issue_tag    (issue_tag),
        .br_valid     (br_valid),
        .br_tag       (br_tag),
        .br_taken     (br_taken),
        .retire_valid (retire_valid),
        .retire_tag   (retire_tag)
    );

    // 100 ns clock period
    always #50 clk = ~clk;

    // =====================================================================
    // Reference rules
    // =====================================================================

    // Slot at program order position k, counted from the model head
    function automatic que_ndx_t slot_at(input int k);
        return que_ndx_t'((int'(m_head) + k) % QENTRIES);
    endfunction

    // Slot the FCU should get this cycle, or -1 for none
    function automatic int ref_fcu_select(input logic fcu_free);
        que_ndx_t slot;
        logic     pass;
        logic     older_valid;
        if (!fcu_free) begin
            return -1;
        end
        for (int k = 0; k < QENTRIES; k++) begin
            slot = slot_at(k);
            pass = 1'b1;
            // A valid sync entry between the head and k blocks k while
            // anything before that sync entry is still valid
            for (int j = 1; j < k; j++) begin
                older_valid = 1'b0;
                for (int i = 0; i < j; i++) begin
                    older_valid = older_valid | m_v[slot_at(i)];
                end
                if (m_v[slot_at(j)] && m_sync[slot_at(j)] && older_valid) begin
                    pass = 1'b0;
                end
            end
            if (m_v[slot] && m_fc[slot] && !m_issued[slot] && pass) begin
                return int'(slot);
            end
        end
        return -1;
    endfunction

    // Branch condition, BLT compares as signed numbers
    function automatic logic ref_taken(input fcu_op_t op, input opnd_t a, input opnd_t b);
        case (op)
            BEQ: return a == b;
            BNE: return a != b;
            BLT: begin
                if (a[OPND_W-1] != b[OPND_W-1]) begin
                    return a[OPND_W-1];
                end
                return a < b;
            end
            default: return 1'b1;
        endcase
    endfunction

    // =====================================================================
    // Compare process
    // =====================================================================

    // Samples 10 ns before each rising edge, when nothing is changing
    always begin : compare
        int exp_sel;
        logic exp_retire;
        logic exp_full;
        @(negedge clk);
        #40;
        if (rst) begin
            m_v = '0;
            m_fc = '0;
            m_sync = '0;
            m_issued = '0;
            m_done = '0;
            m_head = '0;
            m_tail = '0;
            m_count = 0;
            busy = 0;
        end else begin
            exp_sel = ref_fcu_select(busy == 0);
            exp_retire = m_v[m_head] && m_done[m_head];
            exp_full = (m_count == QENTRIES);
            if (issue_valid != (exp_sel >= 0)) begin
                $display("ERR %0t: issue_valid is %b, expected %b", $time, issue_valid,
                         exp_sel >= 0);
                errors++;
            end else if (issue_valid && int'(issue_tag) != exp_sel) begin
                $display("ERR %0t: issue_tag is %0d, expected %0d", $time, issue_tag, exp_sel);
                errors++;
            end
            if (br_valid != (busy == 1)) begin
                $display("ERR %0t: br_valid is %b, expected %b", $time, br_valid, busy == 1);
                errors++;
            end else if (br_valid && br_tag != pend_tag) begin
                $display("ERR %0t: br_tag is %0d, expected %0d", $time, br_tag, pend_tag);
                errors++;
            end else if (br_valid &&
                         br_taken != ref_taken(m_op[pend_tag], m_a[pend_tag], m_b[pend_tag])) begin
                $display("ERR %0t: br_taken is %b for slot %0d", $time, br_taken, br_tag);
                errors++;
            end
            if (retire_valid != exp_retire || (exp_retire && retire_tag != m_head)) begin
                $display("ERR %0t: retire %b tag %0d, expected %b tag %0d", $time,
                         retire_valid, retire_tag, exp_retire, m_head);
                errors++;
            end
            if (queue_full != exp_full || enq_tag != m_tail) begin
                $display("ERR %0t: queue_full %b enq_tag %0d, expected %b and %0d", $time,
                         queue_full, enq_tag, exp_full, m_tail);
                errors++;
            end
            // Apply what the coming edge does, following the observed events
            if (br_valid && m_v[br_tag]) begin
                m_done[br_tag] = 1'b1;
                branches_seen++;
            end
            if (busy > 0) begin
                busy--;
            end
            if (issue_valid) begin
                m_issued[issue_tag] = 1'b1;
                pend_tag = issue_tag;
                busy = FCU_LATENCY;
                issues_seen++;
            end
            if (alu_done && m_v[alu_done_tag] && !m_fc[alu_done_tag]) begin
                m_done[alu_done_tag] = 1'b1;
            end
            if (retire_valid) begin
                m_v[m_head] = 1'b0;
                m_head = m_head + 1'b1;
                m_count--;
                retires_seen++;
            end
            // Fullness is judged on the count before this edge
            if (enq_valid && !exp_full) begin
                m_v[m_tail] = 1'b1;
                m_fc[m_tail] = enq_fc;
                m_sync[m_tail] = enq_sync;
                m_issued[m_tail] = 1'b0;
                m_done[m_tail] = 1'b0;
                m_op[m_tail] = enq_op;
                m_a[m_tail] = enq_a;
                m_b[m_tail] = enq_b;
                m_tail = m_tail + 1'b1;
                m_count++;
            end
        end
    end

    // =====================================================================
    // Stimulus tasks, all inputs change on the falling edge
    // =====================================================================

    task automatic clear_inputs();
        enq_valid = 1'b0;
        enq_fc = 1'b0;
        enq_sync = 1'b0;
        enq_op = BEQ;
        enq_a = '0;
        enq_b = '0;
        alu_done = 1'b0;
        alu_done_tag = '0;
    endtask

    // Writes one entry, first waiting for a free slot
    task automatic push_entry(input logic fc, input logic sync, input fcu_op_t op,
                              input opnd_t a, input opnd_t b);
        int cycles;
        cycles = 0;
        @(negedge clk);
        clear_inputs();
        while (m_count == QENTRIES && cycles < 100) begin
            @(negedge clk);
            clear_inputs();
            cycles++;
        end
        if (m_count == QENTRIES) begin
            $display("Timeout: the queue stayed full and an entry could not be written");
            errors++;
        end else begin
            enq_valid = 1'b1;
            enq_fc = fc;
            enq_sync = sync;
            enq_op = op;
            enq_a = a;
            enq_b = b;
        end
    endtask

    task automatic send_alu_done(input que_ndx_t tag);
        @(negedge clk);
        clear_inputs();
        alu_done = 1'b1;
        alu_done_tag = tag;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            clear_inputs();
        end
    endtask

    task automatic wait_drained(input string test_name);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            clear_inputs();
            cycles++;
        end while (m_count != 0 && cycles < 300);
        if (m_count != 0) begin
            $display("Timeout: the queue did not drain during %s", test_name);
            errors++;
        end
    endtask

    task automatic report_test(input string test_name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("Test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: fail with %0d errors", test_name, errors - start_errors);
        end
    endtask

    // Hard stop in case a wait loop is never left
    initial begin
        #1_000_000;
        $display("Timeout: the simulation ran past its time limit");
        $display("Simulation FAILED");
        $finish;
    end

    // =====================================================================
    // Test sequence
    // =====================================================================

    initial begin : main
        int start;
        int count_before;
        int cycles;
        int pushed;
        que_ndx_t base;
        que_ndx_t saved_tag;
        fcu_op_t op;
        opnd_t a;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        issues_seen = 0;
        branches_seen = 0;
        retires_seen = 0;
        busy = 0;
        void'($urandom(32'h7256c354));
        clk = 1'b0;
        rst = 1'b1;
        clear_inputs();
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // Reset state, then fill the queue with ALU entries and overfill it
        start = errors;
        if (issue_valid || br_valid || retire_valid || queue_full) begin
            $display("ERR %0t: control outputs are not low after reset", $time);
            errors++;
        end
        for (int i = 0; i < QENTRIES; i++) begin
            push_entry(1'b0, 1'b0, BEQ, $urandom, $urandom);
        end
        @(negedge clk);
        clear_inputs();
        if (!queue_full) begin
            $display("ERR %0t: queue_full is low with %0d entries", $time, QENTRIES);
            errors++;
        end
        saved_tag = enq_tag;
        enq_valid = 1'b1;
        enq_fc = 1'b1;
        enq_op = JMP;
        @(negedge clk);
        clear_inputs();
        if (enq_tag != saved_tag || !queue_full || m_count != QENTRIES) begin
            $display("ERR %0t: enqueue while full changed enq_tag to %0d", $time, enq_tag);
            errors++;
        end
        for (int i = 0; i < QENTRIES; i++) begin
            send_alu_done(que_ndx_t'(i));
        end
        wait_drained("reset_and_full");
        report_test("reset_and_full", start);

        // Several independent branches issue oldest first
        start = errors;
        count_before = issues_seen;
        for (int i = 0; i < 5; i++) begin
            push_entry(1'b1, 1'b0, fcu_op_t'($urandom_range(0, 3)), $urandom, $urandom);
        end
        wait_drained("program_order");
        if (issues_seen - count_before != 5) begin
            $display("ERR %0t: %0d issues seen, expected 5", $time, issues_seen - count_before);
            errors++;
        end
        report_test("program_order", start);

        // ALU entry, sync branch, then two branches that the sync entry holds back
        start = errors;
        base = m_tail;
        push_entry(1'b0, 1'b0, BEQ, 32'd1, 32'd1);
        push_entry(1'b1, 1'b1, BNE, 32'd3, 32'd4);
        push_entry(1'b1, 1'b0, BEQ, 32'd7, 32'd7);
        push_entry(1'b1, 1'b0, JMP, 32'd0, 32'd0);
        idle_cycles(12);
        if (!m_issued[base + 3'd1] || m_issued[base + 3'd2] || m_issued[base + 3'd3]) begin
            $display("ERR %0t: sync rule broken, issued mask %b", $time, m_issued);
            errors++;
        end
        send_alu_done(base);
        wait_drained("sync_rule");
        report_test("sync_rule", start);

        // Directed operands on every opcode, then random ones
        start = errors;
        count_before = branches_seen;
        push_entry(1'b1, 1'b0, BEQ, 32'd42, 32'd42);
        push_entry(1'b1, 1'b0, BEQ, 32'd42, 32'd43);
        push_entry(1'b1, 1'b0, BNE, 32'd5, 32'd5);
        push_entry(1'b1, 1'b0, BNE, 32'd5, 32'd6);
        push_entry(1'b1, 1'b0, BLT, 32'hffff_ffff, 32'd1);
        push_entry(1'b1, 1'b0, BLT, 32'd1, 32'hffff_ffff);
        push_entry(1'b1, 1'b0, BLT, 32'd9, 32'd9);
        push_entry(1'b1, 1'b0, JMP, 32'd0, 32'd1);
        for (int i = 0; i < 16; i++) begin
            op = fcu_op_t'($urandom_range(0, 3));
            a = $urandom;
            // Every fourth pair on average is equal so BEQ and BNE see both outcomes
            push_entry(1'b1, 1'b0, op, a, ($urandom_range(0, 3) == 0) ? a : $urandom);
        end
        wait_drained("branch_results");
        if (branches_seen - count_before != 24) begin
            $display("ERR %0t: %0d branch results, expected 24", $time,
                     branches_seen - count_before);
            errors++;
        end
        report_test("branch_results", start);

        // Random mix with random ALU completions, 40 entries wrap the head often
        start = errors;
        count_before = retires_seen;
        pushed = 0;
        cycles = 0;
        while ((pushed < 40 || m_count != 0) && cycles < 3000) begin
            @(negedge clk);
            clear_inputs();
            cycles++;
            if (pushed < 40 && m_count < QENTRIES && $urandom_range(0, 1) == 1) begin
                enq_valid = 1'b1;
                enq_fc = ($urandom_range(0, 2) == 0);
                enq_sync = ($urandom_range(0, 4) == 0);
                enq_op = fcu_op_t'($urandom_range(0, 3));
                enq_a = $urandom;
                enq_b = $urandom;
                pushed++;
            end
            if ($urandom_range(0, 1) == 1) begin
                alu_done = 1'b1;
                alu_done_tag = que_ndx_t'($urandom_range(0, QENTRIES - 1));
            end
        end
        idle_cycles(1);
        if (m_count != 0 || pushed < 40) begin
            $display("Timeout: the random retire test did not finish");
            errors++;
        end else if (retires_seen - count_before != 40) begin
            $display("ERR %0t: %0d retires, expected 40", $time, retires_seen - count_before);
            errors++;
        end
        report_test("random_retire", start);

        $display("Tests run %0d, failed %0d, errors %0d, issues %0d, branches %0d, retires %0d",
                 tests_run, tests_failed, errors, issues_seen, branches_seen, retires_seen);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : fcu_issue_tb

`default_nettype wire
